//--- Bender.yml
package:
  name: imul_iterative

sources:
  - design/imul_pkg.sv
  - design/imul_ctrl.sv
  - design/imul_step_counter.sv
  - design/imul_dpath.sv
  - design/imul_iterative.sv
  - target: test
    files:
      - bench/imul_clock_gen.sv
      - bench/imul_iterative_tb.sv

//--- bench/imul_clock_gen.sv
/*
 * imul clock generator: free running clk with a 20 ns period and a
 * synchronous reset held high for the first three cycles
 */

`timescale 1ns/1ns

module imul_clock_gen (
  output logic clk,
  output logic reset
);

  // half of the 20 ns period
  localparam int HALF_PERIOD = 10;

  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PERIOD clk = ~clk;
    end
  end

  // reset drops 2 ns after the third rising edge, like any other input
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
  end

endmodule

//--- bench/imul_iterative_tb.sv
/*
 * imul iterative testbench: replays the vector file against the DUT,
 * with random idle gaps and response stalls, then back to back
 */

`timescale 1ns/1ns

module imul_iterative_tb;

  import imul_pkg::*;

  localparam int CLK_PERIOD = 20;
  // cycles from one accepting edge to the next with no stall or gap
  localparam int MIN_PERIOD = 34;
  // largest random response stall and idle gap
  localparam int RAND_STALL_MAX = 7;
  localparam int RAND_IDLE_MAX = 3;

  logic       clk;
  logic       reset;
  imul_req_t  req_msg;
  logic       req_val;
  logic       req_rdy;
  imul_resp_t resp_msg;
  logic       resp_val;
  logic       resp_rdy;

  // vectors as read from the file
  imul_req_t  vec_req[$];
  imul_resp_t vec_exp[$];
  int         vec_stall[$];

  int     max_stall;
  logic   vectors_loaded;
  integer seed;

  imul_clock_gen clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  imul_iterative UUT (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // ----------------------------------------------------------
  // error handling and compare tasks
  // ----------------------------------------------------------

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_resp(input string name, input imul_resp_t exp, input imul_resp_t act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %h, got %h",
               $time, name, exp.product, act.product);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  // ----------------------------------------------------------
  // vector file and stimulus helpers
  // ----------------------------------------------------------

  // one line per multiply: op_a op_b product in hex, stall in decimal
  task automatic load_vectors();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] p;
    int          s;
    imul_req_t   req;
    imul_resp_t  resp;
    fd = $fopen("bench/imul_vectors.txt", "r");
    if (fd == 0) begin
      $display("the vectors file bench/imul_vectors.txt could not be opened");
      abort_run();
    end else begin
      max_stall = 0;
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // comment lines start with a hash
        if (line.len() > 0 && line[0] != "#") begin
          fields = $sscanf(line, "%h %h %h %d", a, b, p, s);
          if (fields == 4) begin
            req.op_a = a;
            req.op_b = b;
            resp.product = p;
            vec_req.push_back(req);
            vec_exp.push_back(resp);
            vec_stall.push_back(s);
            // -1 asks for a random stall, so budget for the worst one
            if (s < 0 && max_stall < RAND_STALL_MAX) begin
              max_stall = RAND_STALL_MAX;
            end
            if (s > max_stall) begin
              max_stall = s;
            end
          end
        end
      end
      $fclose(fd);
      if (vec_req.size() == 0) begin
        $display("the vectors file holds no usable vectors");
        abort_run();
      end
    end
  endtask

  // inputs always change 2 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  // one multiply: request, wait for the result, stall, take it
  // busy_req/busy_val drive the request channel while the DUT is busy,
  // chain leaves req_val high after the result for a back-to-back start
  task automatic run_vector(input imul_req_t req, input imul_resp_t exp,
                            input int stall, input imul_req_t busy_req,
                            input logic busy_val, input logic chain);
    int         cycles;
    int         k;
    imul_resp_t held;
    req_msg = req;
    req_val = 1'b1;
    check_bit("req_rdy", 1'b1, req_rdy);
    // accepting edge
    tick();
    req_msg = busy_req;
    req_val = busy_val;
    cycles = 0;
    // count calc cycles, requests must be refused throughout
    while (!resp_val && cycles < 2 * MIN_PERIOD) begin
      check_bit("req_rdy", 1'b0, req_rdy);
      tick();
      cycles = cycles + 1;
    end
    check_count("latency cycles", 32, cycles);
    if (!chain) req_val = 1'b0;
    held = resp_msg;
    check_resp("resp_msg", exp, resp_msg);
    // back-pressure: result and handshake outputs must hold
    for (k = 0; k < stall; k++) begin
      resp_rdy = 1'b0;
      tick();
      check_bit("resp_val", 1'b1, resp_val);
      check_bit("req_rdy", 1'b0, req_rdy);
      check_resp("resp_msg", held, resp_msg);
    end
    resp_rdy = 1'b1;
    // response taken on this edge
    tick();
    resp_rdy = 1'b0;
    check_bit("req_rdy", 1'b1, req_rdy);
    check_bit("resp_val", 1'b0, resp_val);
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------

  initial begin : stimulus
    int        i;
    int        idle;
    int        stall;
    imul_req_t busy;
    imul_req_t next;
    req_msg = '0;
    req_val = 1'b0;
    resp_rdy = 1'b0;
    vectors_loaded = 1'b0;
    seed = 32'he70e;
    load_vectors();
    vectors_loaded = 1'b1;
    wait (reset == 1'b0);
    // state right after reset
    check_bit("req_rdy", 1'b1, req_rdy);
    check_bit("resp_val", 1'b0, resp_val);

    // first pass with idle gaps, stalls and busy requests
    for (i = 0; i < vec_req.size(); i++) begin
      idle = $unsigned($random(seed)) % (RAND_IDLE_MAX + 1);
      repeat (idle) tick();
      if (vec_stall[i] < 0) begin
        stall = $unsigned($random(seed)) % (RAND_STALL_MAX + 1);
      end else begin
        stall = vec_stall[i];
      end
      // different operands offered while the DUT is busy
      busy.op_a = ~vec_req[i].op_a;
      busy.op_b = vec_req[i].op_b ^ 32'h5a5a_5a5a;
      run_vector(vec_req[i], vec_exp[i], stall, busy, 1'b1, 1'b0);
    end

    // second pass back to back, next request already waiting
    for (i = 0; i < vec_req.size(); i++) begin
      if (i + 1 < vec_req.size()) begin
        next = vec_req[i + 1];
        run_vector(vec_req[i], vec_exp[i], 0, next, 1'b1, 1'b1);
      end else begin
        next = '0;
        run_vector(vec_req[i], vec_exp[i], 0, next, 1'b0, 1'b0);
      end
    end

    $display("** PASS **");
    $finish;
  end

  // ----------------------------------------------------------
  // watchdog
  // ----------------------------------------------------------

  // two passes, each vector at most a full period plus stall and gap
  initial begin : watchdog
    int limit_ns;
    wait (vectors_loaded);
    limit_ns = 2 * vec_req.size() * (MIN_PERIOD + max_stall + RAND_IDLE_MAX) * CLK_PERIOD
               + 50 * CLK_PERIOD;
    #(limit_ns);
    $display("timeout: the run did not finish within %0d ns", limit_ns);
    abort_run();
  end

endmodule

//--- bench/imul_vectors.txt
# op_a op_b product (hex, two's complement) stall (decimal, -1 = random 0..7)
# stall is the number of cycles resp_rdy stays low after resp_val rises
00000000 00000000 0000000000000000 0
00000001 00000001 0000000000000001 0
00000000 7fffffff 0000000000000000 2
00000001 ffffffff ffffffffffffffff 0
00000007 00000006 000000000000002a 1
fffffffd 00000005 fffffffffffffff1 0
00000005 fffffffd fffffffffffffff1 3
fffffff9 fffffffb 0000000000000023 -1
80000000 80000000 4000000000000000 0
80000000 ffffffff 0000000080000000 5
ffffffff 80000000 0000000080000000 -1
7fffffff 7fffffff 3fffffff00000001 0
80000000 7fffffff c000000080000000 2
ffffffff ffffffff 0000000000000001 0
00010000 00010000 0000000100000000 -1
12345678 00000010 0000000123456780 4
0000ffff 0000ffff 00000000fffe0001 0
ffff0000 00010000 ffffffff00000000 7
00000064 ffffff9c ffffffffffffd8f0 -1
7fffffff ffffffff ffffffff80000001 1
0000c350 0000c350 000000009502f900 0
80000000 00000001 ffffffff80000000 0

//--- design/imul_ctrl.sv
/*
 * imul control FSM: runs the request and response handshakes and
 * steers the datapath and the step counter through one multiply
 */

`timescale 1ns/1ns

module imul_ctrl (
  input  logic clk,
  input  logic reset,

  // request channel handshake
  input  logic req_val,
  output logic req_rdy,

  // response channel handshake
  output logic resp_val,
  input  logic resp_rdy,

  // from the step counter
  input  logic last,

  // to datapath and counter
  output logic load,
  output logic step
);

  import imul_pkg::*;

  imul_state_e state;
  imul_state_e state_next;

  // handshake fire signals
  logic req_fire;
  logic resp_fire;

  // ----------------------------------------------------------
  // output decode
  // ----------------------------------------------------------

  // ready for a new request only when nothing is in flight
  assign req_rdy  = (state == IDLE);
  // result is valid for as long as we sit in done
  assign resp_val = (state == DONE);

  assign req_fire  = req_val && req_rdy;
  assign resp_fire = resp_val && resp_rdy;

  // capture operands on the accepting edge
  assign load = req_fire;
  // one shift-add on every edge spent in calc
  assign step = (state == CALC);

  // ----------------------------------------------------------
  // next state
  // ----------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (req_fire) begin
          state_next = CALC;
        end
      end
      CALC: begin
        // counter flags the final step
        if (last) begin
          state_next = DONE;
        end
      end
      DONE: begin
        // stall here until the consumer takes the product
        if (resp_fire) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule

//--- design/imul_dpath.sv
/*
 * imul datapath: unsigned shift-add over operand magnitudes,
 * with the product sign restored at the output
 */

`timescale 1ns/1ns

module imul_dpath (
  input  logic                 clk,
  input  logic                 reset,

  // operands from the request channel
  input  imul_pkg::imul_req_t  req_msg,

  // control from the FSM
  input  logic                 load,
  input  logic                 step,

  // product to the response channel
  output imul_pkg::imul_resp_t resp_msg
);

  // ----------------------------------------------------------
  // operand sign handling
  // ----------------------------------------------------------

  // operand sign bits
  logic sign_a;
  logic sign_b;

  // operand magnitudes, most negative value maps to 2^31
  logic [31:0] mag_a;
  logic [31:0] mag_b;

  assign sign_a = req_msg.op_a[31];
  assign sign_b = req_msg.op_b[31];

  assign mag_a = sign_a ? (~req_msg.op_a + 32'd1) : req_msg.op_a;
  assign mag_b = sign_b ? (~req_msg.op_b + 32'd1) : req_msg.op_b;

  // ----------------------------------------------------------
  // shifting operand registers
  // ----------------------------------------------------------

  // multiplicand, zero-extended and moved left one bit per step
  logic [63:0] mcand_q;
  // multiplier, moved right one bit per step
  logic [31:0] mplier_q;

  always_ff @(posedge clk) begin
    if (load) begin
      mcand_q  <= {32'd0, mag_a};
      mplier_q <= mag_b;
    end else if (step) begin
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // ----------------------------------------------------------
  // accumulator
  // ----------------------------------------------------------

  // unsigned partial product
  logic [63:0] acc_q;
  // product is negative when exactly one operand was negative
  logic        neg_q;

  // current multiplier bit selects the shifted multiplicand
  logic [63:0] addend;

  assign addend = mplier_q[0] ? mcand_q : 64'd0;

  always_ff @(posedge clk) begin
    if (reset) begin
      acc_q <= 64'd0;
      neg_q <= 1'b0;
    end else if (load) begin
      acc_q <= 64'd0;
      neg_q <= sign_a ^ sign_b;
    end else if (step) begin
      acc_q <= acc_q + addend;
    end
  end

  // ----------------------------------------------------------
  // sign correction
  // ----------------------------------------------------------

  // magnitude of at most 2^62, so negation never overflows
  logic [63:0] product;

  assign product = neg_q ? (~acc_q + 64'd1) : acc_q;

  // registers hold steady outside calc, so the product is
  // stable for the whole time the response waits in done
  assign resp_msg.product = product;

endmodule

//--- design/imul_iterative.sv
/*
 * imul iterative: 32-bit signed multiplier, one request in flight,
 * 32 shift-add steps between the request and response channels
 */

`timescale 1ns/1ns

module imul_iterative (
  input  logic                 clk,
  input  logic                 reset,

  // request channel
  input  imul_pkg::imul_req_t  req_msg,
  input  logic                 req_val,
  output logic                 req_rdy,

  // response channel
  output imul_pkg::imul_resp_t resp_msg,
  output logic                 resp_val,
  input  logic                 resp_rdy
);

  // capture operands, clear accumulator and counter
  logic load;
  // one shift-add step
  logic step;
  // final step in progress
  logic last;

  // ----------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------

  imul_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .last     (last),
    .load     (load),
    .step     (step)
  );

  // ----------------------------------------------------------
  // step counter
  // ----------------------------------------------------------

  // cleared on the accepting edge, counts every calc cycle
  imul_step_counter counter (
    .clk    (clk),
    .reset  (reset),
    .clear  (load),
    .enable (step),
    .last   (last)
  );

  // ----------------------------------------------------------
  // datapath
  // ----------------------------------------------------------

  imul_dpath dpath (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .load     (load),
    .step     (step),
    .resp_msg (resp_msg)
  );

endmodule

//--- design/imul_pkg.sv
/*
 * imul package: shared message structs, control state encoding
 * and the shift-add step constants for the iterative multiplier
 */

package imul_pkg;

  // ----------------------------------------------------------
  // step constants
  // ----------------------------------------------------------

  // one shift-add step per multiplier bit
  localparam int unsigned IMUL_STEPS = 32;
  // counter width, enough to hold 0 .. IMUL_STEPS-1
  localparam int unsigned IMUL_STEP_W = 5;

  // ----------------------------------------------------------
  // messages
  // ----------------------------------------------------------

  // request: both operands, two's complement
  typedef struct packed {
    logic signed [31:0] op_a;
    logic signed [31:0] op_b;
  } imul_req_t;

  // response: full-width signed product
  typedef struct packed {
    logic signed [63:0] product;
  } imul_resp_t;

  // ----------------------------------------------------------
  // control states
  // ----------------------------------------------------------

  // idle waits for a request, calc runs the steps, done holds the result
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } imul_state_e;

endpackage

//--- design/imul_step_counter.sv
/*
 * imul step counter: counts shift-add steps and flags the last one
 */

`timescale 1ns/1ns

module imul_step_counter (
  input  logic clk,
  input  logic reset,

  // clear restarts the count, enable advances it
  input  logic clear,
  input  logic enable,

  // high while the final step is being performed
  output logic last
);

  import imul_pkg::*;

  logic [IMUL_STEP_W-1:0] count;

  // ----------------------------------------------------------
  // count register
  // ----------------------------------------------------------

  // clear wins over enable, a new request restarts from zero
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (enable) begin
      // wraps back to zero after the final step
      count <= count + 1'b1;
    end
  end

  // ----------------------------------------------------------
  // terminal count
  // ----------------------------------------------------------

  assign last = (count == IMUL_STEP_W'(IMUL_STEPS - 1));

endmodule

//--- imul_iterative.f
design/imul_pkg.sv
design/imul_ctrl.sv
design/imul_step_counter.sv
design/imul_dpath.sv
design/imul_iterative.sv
bench/imul_clock_gen.sv
bench/imul_iterative_tb.sv
